// ==== Bender.yml ====
package:
  name: noc_router

sources:
  # Shared package first
  - common/noc_pkg.sv
  # Input ports
  - input_port/input_fifo.sv
  - input_port/route_calc.sv
  # Allocator and output stage
  - switch/switch_alloc.sv
  - switch/output_stage.sv
  # Top level
  - hdl/noc_router.sv
  # Testbench
  - target: test
    files:
      - test/tb_noc_router.sv

// ==== common/noc_pkg.sv ====
package noc_pkg;

  // ----------------------------------------------------------
  // Router geometry
  // ----------------------------------------------------------
  localparam int NUM_PORTS  = 5;  // Local plus four compass ports

  // Port index meaning, shared by route calc and crossbar
  localparam int PORT_LOCAL = 0;  // Core attached to this router
  localparam int PORT_NORTH = 1;
  localparam int PORT_EAST  = 2;
  localparam int PORT_SOUTH = 3;
  localparam int PORT_WEST  = 4;

  // ----------------------------------------------------------
  // Flit fields
  // ----------------------------------------------------------
  localparam int COORD_W   = 2;   // 4x4 mesh
  localparam int PAYLOAD_W = 16;

  // ----------------------------------------------------------
  // Input queue sizing
  // ----------------------------------------------------------
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);      // Read/write pointer width
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);  // Count must reach FIFO_DEPTH

  // One X or Y mesh coordinate
  typedef logic [COORD_W-1:0] coord_t;

  // Data carried by a flit, opaque to the router
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // Port number, 0 to NUM_PORTS-1
  typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

  // One bit per port: requests, grants, valids, readies
  typedef logic [NUM_PORTS-1:0] port_vec_t;

  // Flit as it moves between routers, 20 bits
  typedef struct packed {
    coord_t   x_dest;   // Destination column
    coord_t   y_dest;   // Destination row
    payload_t payload;
  } flit_t;

  // One flit per port
  typedef flit_t [NUM_PORTS-1:0] flit_arr_t;

  // Requests are indexed by input, grants by output
  typedef port_vec_t [NUM_PORTS-1:0] req_mat_t;

endpackage

// ==== hdl/noc_router.sv ====
`timescale 1ns/10ps

module noc_router #(
  parameter noc_pkg::coord_t X_LOC = '0,  // Column of this router in the mesh
  parameter noc_pkg::coord_t Y_LOC = '0   // Row of this router in the mesh
) (
  input  logic               clk,
  input  logic               reset_n,

  // Upstream side, one lane per port
  input  noc_pkg::flit_arr_t i_flit,
  input  noc_pkg::port_vec_t i_valid,
  output noc_pkg::port_vec_t o_ready,

  // Downstream side, one lane per port
  output noc_pkg::flit_arr_t o_flit,
  output noc_pkg::port_vec_t o_valid,
  input  noc_pkg::port_vec_t i_ready
);

  noc_pkg::flit_arr_t head_flit;   // Oldest flit of each input queue
  noc_pkg::port_vec_t head_valid;  // Input queue holds a flit
  noc_pkg::req_mat_t  req;         // Row per input, one-hot output request
  noc_pkg::req_mat_t  grant;       // Row per output, one-hot granted input
  noc_pkg::port_vec_t pop;         // Dequeue per input
  noc_pkg::port_vec_t out_free;    // Output register can take a flit this cycle

  // ----------------------------------------------------------
  // Input ports: queue plus route calc on the queue head
  // ----------------------------------------------------------
  for (genvar p = 0; p < noc_pkg::NUM_PORTS; p++) begin : gen_port
    input_fifo i_input_fifo (
      .clk          (clk),
      .reset_n      (reset_n),
      .i_flit       (i_flit[p]),      // From upstream router
      .i_valid      (i_valid[p]),
      .o_ready      (o_ready[p]),     // Low only when full
      .i_pop        (pop[p]),         // From switch allocator
      .o_head_flit  (head_flit[p]),
      .o_head_valid (head_valid[p])
    );

    route_calc #(
      .X_LOC (X_LOC),
      .Y_LOC (Y_LOC)
    ) i_route_calc (
      .i_flit  (head_flit[p]),
      .i_valid (head_valid[p]),
      .o_req   (req[p])             // Row p of the request matrix
    );
  end

  // ----------------------------------------------------------
  // Arbitration, one round-robin pointer per output
  // ----------------------------------------------------------
  switch_alloc i_switch_alloc (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_req      (req),
    .i_out_free (out_free),
    .o_grant    (grant),
    .o_pop      (pop)
  );

  // Crossbar and output registers
  output_stage i_output_stage (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_grant     (grant),
    .i_head_flit (head_flit),
    .o_out_free  (out_free),
    .o_flit      (o_flit),
    .o_valid     (o_valid),
    .i_ready     (i_ready)
  );

endmodule

// ==== input_port/input_fifo.sv ====
`timescale 1ns/10ps

module input_fifo (
  input  logic           clk,
  input  logic           reset_n,

  // Write side, valid/ready from upstream
  input  noc_pkg::flit_t i_flit,
  input  logic           i_valid,
  output logic           o_ready,

  // Read side, head exposed to route calc and crossbar
  input  logic           i_pop,
  output noc_pkg::flit_t o_head_flit,
  output logic           o_head_valid
);

  noc_pkg::flit_t                 mem [noc_pkg::FIFO_DEPTH];  // Flit storage
  logic [noc_pkg::FIFO_PTR_W-1:0] wr_ptr;   // Next slot to write
  logic [noc_pkg::FIFO_PTR_W-1:0] rd_ptr;   // Slot holding the head
  logic [noc_pkg::FIFO_CNT_W-1:0] count;    // Flits held
  logic                           push;
  logic                           pop;

  // Wrap a pointer at the queue depth
  function automatic logic [noc_pkg::FIFO_PTR_W-1:0] ptr_inc(
    input logic [noc_pkg::FIFO_PTR_W-1:0] ptr
  );
    if (ptr == noc_pkg::FIFO_PTR_W'(noc_pkg::FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign o_ready      = (count != noc_pkg::FIFO_CNT_W'(noc_pkg::FIFO_DEPTH));  // Not full
  assign o_head_valid = (count != '0);
  assign o_head_flit  = mem[rd_ptr];
  assign push         = i_valid & o_ready;        // Handshake on the write side
  assign pop          = i_pop & o_head_valid;

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_flit;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop)  rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;  // Write only
        2'b01:   count <= count - 1'b1;  // Read only
        default: count <= count;         // Both or neither
      endcase
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  // Allocator only pops a queue whose head it saw valid
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!reset_n) i_pop |-> o_head_valid
  ) else $error("input_fifo: pop while empty");

  a_count_max: assert property (
    @(posedge clk) disable iff (!reset_n) count <= noc_pkg::FIFO_CNT_W'(noc_pkg::FIFO_DEPTH)
  ) else $error("input_fifo: count above depth");

endmodule

// ==== input_port/route_calc.sv ====
`timescale 1ns/10ps

module route_calc #(
  parameter noc_pkg::coord_t X_LOC = '0,  // Own column
  parameter noc_pkg::coord_t Y_LOC = '0   // Own row
) (
  input  noc_pkg::flit_t     i_flit,   // Head of the input queue
  input  logic               i_valid,
  output noc_pkg::port_vec_t o_req     // One-hot output request
);

  noc_pkg::port_idx_t dir;  // Chosen output port

  // ----------------------------------------------------------
  // Dimension order: resolve X fully, then Y
  // ----------------------------------------------------------
  always_comb begin
    if (i_flit.x_dest > X_LOC) begin
      dir = noc_pkg::port_idx_t'(noc_pkg::PORT_EAST);
    end else if (i_flit.x_dest < X_LOC) begin
      dir = noc_pkg::port_idx_t'(noc_pkg::PORT_WEST);
    end else if (i_flit.y_dest > Y_LOC) begin
      dir = noc_pkg::port_idx_t'(noc_pkg::PORT_NORTH);
    end else if (i_flit.y_dest < Y_LOC) begin
      dir = noc_pkg::port_idx_t'(noc_pkg::PORT_SOUTH);
    end else begin
      dir = noc_pkg::port_idx_t'(noc_pkg::PORT_LOCAL);  // Arrived, eject to core
    end
  end

  // Decode to a request row, nothing when the queue is empty
  always_comb begin
    if (i_valid) begin
      o_req = noc_pkg::port_vec_t'(1) << dir;
    end else begin
      o_req = '0;
    end
  end

endmodule

// ==== noc_router.f ====
common/noc_pkg.sv
input_port/input_fifo.sv
input_port/route_calc.sv
switch/switch_alloc.sv
switch/output_stage.sv
hdl/noc_router.sv
test/tb_noc_router.sv

// ==== switch/output_stage.sv ====
`timescale 1ns/10ps

module output_stage (
  input  logic               clk,
  input  logic               reset_n,
  input  noc_pkg::req_mat_t  i_grant,      // Row per output, one-hot input select
  input  noc_pkg::flit_arr_t i_head_flit,  // Queue heads, one per input
  output noc_pkg::port_vec_t o_out_free,   // Output can load this cycle
  output noc_pkg::flit_arr_t o_flit,       // To downstream routers
  output noc_pkg::port_vec_t o_valid,
  input  noc_pkg::port_vec_t i_ready       // From downstream routers
);

  noc_pkg::flit_arr_t sel_flit;  // Crossbar output, before the register

  // ----------------------------------------------------------
  // Crossbar, grant row picks the input
  // ----------------------------------------------------------
  always_comb begin
    sel_flit = '0;
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
        if (i_grant[o][i]) sel_flit[o] = i_head_flit[i];
      end
    end
  end

  // Empty, or emptied by a handshake this cycle
  assign o_out_free = ~o_valid | i_ready;

  // ----------------------------------------------------------
  // Holding registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      o_valid <= '0;
    end else begin
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
        if (|i_grant[o]) begin
          o_valid[o] <= 1'b1;   // New flit, possibly replacing a drained one
        end else if (i_ready[o]) begin
          o_valid[o] <= 1'b0;   // Drained with nothing behind it
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      if (|i_grant[o]) o_flit[o] <= sel_flit[o];
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  for (genvar g = 0; g < noc_pkg::NUM_PORTS; g++) begin : gen_chk
    // Stalled output keeps offering the same flit
    a_hold_stable: assert property (
      @(posedge clk) disable iff (!reset_n)
      (o_valid[g] && !i_ready[g]) |=> (o_valid[g] && $stable(o_flit[g]))
    ) else $error("output_stage: output %0d changed while stalled", g);
  end

endmodule

// ==== switch/switch_alloc.sv ====
`timescale 1ns/10ps

module switch_alloc (
  input  logic               clk,
  input  logic               reset_n,
  input  noc_pkg::req_mat_t  i_req,       // Row per input, bit per output
  input  noc_pkg::port_vec_t i_out_free,  // From output stage
  output noc_pkg::req_mat_t  o_grant,     // Row per output, bit per input
  output noc_pkg::port_vec_t o_pop        // Per input, head is consumed
);

  noc_pkg::port_idx_t [noc_pkg::NUM_PORTS-1:0] rr_ptr;   // Highest priority input per output
  noc_pkg::port_idx_t [noc_pkg::NUM_PORTS-1:0] gnt_idx;  // Input granted per output

  // ----------------------------------------------------------
  // Round-robin search per output
  // ----------------------------------------------------------
  always_comb begin
    int   idx;
    logic found;
    o_grant = '0;
    gnt_idx = '0;
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      found = 1'b0;
      // Walk inputs starting at the pointer, wrapping once
      for (int k = 0; k < noc_pkg::NUM_PORTS; k++) begin
        idx = int'(rr_ptr[o]) + k;
        if (idx >= noc_pkg::NUM_PORTS) begin
          idx = idx - noc_pkg::NUM_PORTS;
        end
        if (!found && i_out_free[o] && i_req[idx][o]) begin
          found           = 1'b1;                            // First hit wins
          o_grant[o][idx] = 1'b1;
          gnt_idx[o]      = noc_pkg::port_idx_t'(idx);
        end
      end
    end
  end

  // An input requests one output at most, so OR the rows
  always_comb begin
    o_pop = '0;
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      o_pop |= o_grant[o];
    end
  end

  // ----------------------------------------------------------
  // Pointer update, one past the winner
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rr_ptr <= '0;  // Input 0 first after reset
    end else begin
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
        if (|o_grant[o]) begin
          if (gnt_idx[o] == noc_pkg::port_idx_t'(noc_pkg::NUM_PORTS - 1)) begin
            rr_ptr[o] <= '0;
          end else begin
            rr_ptr[o] <= gnt_idx[o] + 1'b1;
          end
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  for (genvar g = 0; g < noc_pkg::NUM_PORTS; g++) begin : gen_chk
    // One winner per output at most
    a_grant_onehot: assert property (
      @(posedge clk) disable iff (!reset_n) $onehot0(o_grant[g])
    ) else $error("switch_alloc: output %0d granted to several inputs", g);

    // Never overwrite a held flit that downstream has not taken
    a_grant_free: assert property (
      @(posedge clk) disable iff (!reset_n) (|o_grant[g]) |-> i_out_free[g]
    ) else $error("switch_alloc: grant to busy output %0d", g);
  end

endmodule

// ==== test/tb_noc_router.sv ====
`timescale 1ns/10ps

module tb_noc_router;

  // ----------------------------------------------------------
  // Run constants
  // ----------------------------------------------------------
  localparam int              SEED           = 65;
  localparam noc_pkg::coord_t X_LOC          = 2'd1;  // Router under test sits at (1,2)
  localparam noc_pkg::coord_t Y_LOC          = 2'd2;
  localparam int              FLITS_PER_PORT = 200;
  localparam int              TOTAL_FLITS    = FLITS_PER_PORT * noc_pkg::NUM_PORTS;
  localparam int              TIMEOUT_CYCLES = TOTAL_FLITS * 20 + 100;
  localparam int              SRC_W          = 3;  // Source port in payload top bits
  localparam int              SEQ_W          = noc_pkg::PAYLOAD_W - SRC_W;
  localparam int              NUM_PAIRS      = noc_pkg::NUM_PORTS * noc_pkg::NUM_PORTS;

  // Test indices for the per-test counters
  localparam int T_RESET = 0;
  localparam int T_ROUTE = 1;
  localparam int T_ORDER = 2;
  localparam int T_HOLD  = 3;
  localparam int T_DONE  = 4;
  localparam int NUM_TESTS = 5;

  logic               clk;
  logic               reset_n;
  noc_pkg::flit_arr_t i_flit;
  noc_pkg::port_vec_t i_valid;
  noc_pkg::port_vec_t o_ready;
  noc_pkg::flit_arr_t o_flit;
  noc_pkg::port_vec_t o_valid;
  noc_pkg::port_vec_t i_ready;

  noc_pkg::flit_t exp_q [NUM_PAIRS][$];         // Expected flits per (source, output)
  int             sent_cnt [noc_pkg::NUM_PORTS];  // Accepted per input
  int             gap_cnt [noc_pkg::NUM_PORTS];   // Idle cycles before next flit
  int             recv_total = 0;
  int             cycle_cnt  = 0;
  int             checks [NUM_TESTS];
  int             errs [NUM_TESTS];
  logic           hold_pend [noc_pkg::NUM_PORTS];  // Output stalled at the last edge
  noc_pkg::flit_t held_flit [noc_pkg::NUM_PORTS];

  noc_router #(
    .X_LOC (X_LOC),
    .Y_LOC (Y_LOC)
  ) i_noc_router (
    .clk     (clk),
    .reset_n (reset_n),
    .i_flit  (i_flit),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .o_flit  (o_flit),
    .o_valid (o_valid),
    .i_ready (i_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ----------------------------------------------------------
  // Reference model and helpers
  // ----------------------------------------------------------
  // X first, then Y, else eject locally
  function automatic noc_pkg::port_idx_t model_route(input noc_pkg::flit_t f);
    if (f.x_dest > X_LOC) begin
      return noc_pkg::port_idx_t'(noc_pkg::PORT_EAST);
    end else if (f.x_dest < X_LOC) begin
      return noc_pkg::port_idx_t'(noc_pkg::PORT_WEST);
    end else if (f.y_dest > Y_LOC) begin
      return noc_pkg::port_idx_t'(noc_pkg::PORT_NORTH);
    end else if (f.y_dest < Y_LOC) begin
      return noc_pkg::port_idx_t'(noc_pkg::PORT_SOUTH);
    end
    return noc_pkg::port_idx_t'(noc_pkg::PORT_LOCAL);
  endfunction

  function automatic int pair_idx(input int src, input int out);
    return src * noc_pkg::NUM_PORTS + out;
  endfunction

  // Random destination, payload tags source and sequence
  function automatic noc_pkg::flit_t make_flit(input int src, input int seq);
    noc_pkg::flit_t f;
    f.x_dest  = noc_pkg::coord_t'($urandom_range(0, 3));
    f.y_dest  = noc_pkg::coord_t'($urandom_range(0, 3));
    f.payload = {SRC_W'(src), SEQ_W'(seq)};
    return f;
  endfunction

  function automatic bit all_sent();
    for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
      if (sent_cnt[p] < FLITS_PER_PORT) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check_flit(input string name, input noc_pkg::flit_t act,
                            input noc_pkg::flit_t exp, input int test);
    checks[test]++;
    if (act !== exp) begin
      errs[test]++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_port(input string name, input noc_pkg::port_idx_t act,
                            input noc_pkg::port_idx_t exp, input int test);
    checks[test]++;
    if (act !== exp) begin
      errs[test]++;
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, act, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp,
                           input int test);
    checks[test]++;
    if (act !== exp) begin
      errs[test]++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, act, exp);
    end
  endtask

  // One delivered flit against route model and pair queue
  task automatic take_output(input int p, input noc_pkg::flit_t f);
    int src;
    int idx;
    src = int'(f.payload[noc_pkg::PAYLOAD_W-1 -: SRC_W]);
    recv_total++;
    check_port($sformatf("route of o_flit[%0d]", p), noc_pkg::port_idx_t'(p),
               model_route(f), T_ROUTE);
    checks[T_ORDER]++;
    if (src >= noc_pkg::NUM_PORTS) begin
      errs[T_ORDER]++;
      $display("Output %0d delivered a flit with bad source tag %0d at %0t", p, src, $time);
    end else begin
      idx = pair_idx(src, p);
      if (exp_q[idx].size() == 0) begin
        errs[T_ORDER]++;
        $display("Output %0d delivered a flit from input %0d that was never sent, at %0t",
                 p, src, $time);
      end else begin
        check_flit($sformatf("o_flit[%0d]", p), f, exp_q[idx].pop_front(), T_ORDER);
      end
    end
  endtask

  // Upstream lanes plus random downstream readiness, one edge
  task automatic drive_step();
    for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
      if (i_valid[p] && o_ready[p]) begin  // Handshake at this edge
        exp_q[pair_idx(p, model_route(i_flit[p]))].push_back(i_flit[p]);
        sent_cnt[p]++;
        gap_cnt[p] = $urandom_range(0, 3);
        i_valid[p] <= 1'b0;
      end
      if (!(i_valid[p] && !o_ready[p]) && sent_cnt[p] < FLITS_PER_PORT) begin  // Lane free
        if (gap_cnt[p] == 0) begin
          i_flit[p]  <= make_flit(p, sent_cnt[p]);
          i_valid[p] <= 1'b1;
        end else begin
          gap_cnt[p]--;
        end
      end
      i_ready[p] <= ($urandom_range(0, 99) >= 30);  // Low 30% of cycles
    end
  endtask

  task automatic report_test(input string name, input int test);
    $display("%-12s %0d checks, %0d errors, %s", name, checks[test], errs[test],
             (errs[test] == 0) ? "ok" : "FAILED");
  endtask

  // ----------------------------------------------------------
  // Output monitor
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (reset_n) begin
      for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
        if (hold_pend[p]) begin  // Stalled at the previous edge
          check_bit($sformatf("o_valid[%0d]", p), o_valid[p], 1'b1, T_HOLD);
          check_flit($sformatf("o_flit[%0d]", p), o_flit[p], held_flit[p], T_HOLD);
        end
        hold_pend[p] = o_valid[p] && !i_ready[p];
        held_flit[p] = o_flit[p];
        if (o_valid[p] && i_ready[p]) take_output(p, o_flit[p]);
      end
    end else begin
      for (int p = 0; p < noc_pkg::NUM_PORTS; p++) hold_pend[p] = 1'b0;
    end
  end

  // Watchdog
  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout after %0d cycles with %0d of %0d flits received",
             cycle_cnt, recv_total, TOTAL_FLITS);
    $display("sim failed");
    $finish;
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    int total_errs;
    int total_checks;
    void'($urandom(SEED));
    reset_n = 1'b0;
    i_flit  = '0;
    i_valid = '0;
    i_ready = '1;
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;

    // Idle router after reset
    repeat (4) begin
      @(posedge clk);
      for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
        check_bit($sformatf("o_valid[%0d]", p), o_valid[p], 1'b0, T_RESET);
        check_bit($sformatf("o_ready[%0d]", p), o_ready[p], 1'b1, T_RESET);
      end
    end
    report_test("reset", T_RESET);

    while (!all_sent()) begin  // Random traffic with back-pressure
      @(posedge clk);
      drive_step();
    end
    @(posedge clk);
    i_ready <= '1;             // Drain
    while (recv_total < TOTAL_FLITS) @(negedge clk);
    repeat (10) @(negedge clk);

    report_test("routing", T_ROUTE);
    report_test("order", T_ORDER);
    report_test("hold", T_HOLD);

    checks[T_DONE]++;
    if (recv_total != TOTAL_FLITS) begin
      errs[T_DONE]++;
      $display("Received %0d flits but %0d were sent", recv_total, TOTAL_FLITS);
    end
    for (int i = 0; i < NUM_PAIRS; i++) begin
      checks[T_DONE]++;
      if (exp_q[i].size() != 0) begin
        errs[T_DONE]++;
        $display("%0d flits from input %0d to output %0d never arrived",
                 exp_q[i].size(), i / noc_pkg::NUM_PORTS, i % noc_pkg::NUM_PORTS);
      end
    end
    report_test("completion", T_DONE);

    total_errs   = 0;
    total_checks = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total_errs   += errs[t];
      total_checks += checks[t];
    end
    $display("Tests %0d, checks %0d, errors %0d, flits %0d", NUM_TESTS, total_checks,
             total_errs, recv_total);
    if (total_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
